// File: src/ib_params.svh
// instruction buffer parameters
// depth, widths, debug command codes and the opcode fields used to
// build injected debug instructions

`ifndef IB_PARAMS_SVH
`define IB_PARAMS_SVH

// buffer geometry
`define IB_DEPTH      4
`define INSTR_W       32
`define PC_W          31    // pc bits 31:1

// debug command types
`define DBG_TYPE_GPR  2'd0
`define DBG_TYPE_CSR  2'd1
`define DBG_TYPE_MEM  2'd2  // abstract memory access, not injected here

// debug-only fence csr
`define CSR_DFENCE    12'h7c4

// rv32 encoding fields
`define OPC_OP        7'b0110011
`define OPC_SYSTEM    7'b1110011
`define F3_OR         3'b110
`define F3_CSRRW      3'b001
`define F3_CSRRS      3'b010

`endif

// File: src/ib_pkg.sv
// instruction buffer types
// pc packet, aligner slot, debug command and the per-cycle steering
// word shared by every payload array

`include "ib_params.svh"

package ib_pkg;

   // travels with each instruction, msb first as decode expects it
   typedef struct packed {
      logic                icaf_second;  // fault on second half of a 4B inst
      logic                dbecc;        // double-bit ecc error
      logic                sbecc;        // single-bit ecc error
      logic                perr;         // parity error
      logic                icaf;         // access fault
      logic [`PC_W:1]      pc;
      logic                pc4;          // 4B inst, else 2B
   } ib_pc_pkt_t;

   // one aligner output slot
   typedef struct packed {
      logic                valid;
      logic [`INSTR_W-1:0] instr;
      ib_pc_pkt_t          pc_pkt;
   } fetch_slot_t;

   // debug module command
   typedef struct packed {
      logic                valid;
      logic                write;
      logic [1:0]          cmd_type;     // gpr, csr or mem
      logic [1:0]          size;         // 00 1B, 01 2B, 10 4B
      logic [31:0]         addr;
   } dbg_cmd_t;

   // steering for one cycle, same for all arrays
   typedef struct packed {
      logic [3:0]          wr_i0;        // slot 0 into entry n
      logic [3:1]          wr_i1;        // slot 1 into entry n
      logic                sh_1_0;
      logic                sh_2_1;
      logic                sh_3_2;
      logic                sh_2_0;
      logic                sh_3_1;
   } ib_ctl_t;

endpackage

// File: src/ib_valid_ctl.sv
// instruction buffer valid and steering control
// keeps the entry valid bits, applies the room check to fetch, and
// derives write and shift selects for the payload arrays

`timescale 1ns/100ps

`include "ib_params.svh"

module ib_valid_ctl
   import ib_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 flush,       // one-cycle pulse
   input  logic                 i0_valid,
   input  logic                 i1_valid,
   input  logic                 dbg_active,  // debug inst goes to entry 0
   input  logic                 i0_decode,
   input  logic                 i1_decode,
   output ib_ctl_t              ctl,
   output logic [`IB_DEPTH-1:0] ib_valid
);

   logic                 flush_q;
   logic                 i0_acc;
   logic                 i1_acc;
   logic                 shift0;
   logic                 shift1;
   logic                 shift2;
   logic [`IB_DEPTH-1:0] shift_val;   // valids after this cycle's decode
   logic [`IB_DEPTH-1:0] i0_wen;      // writes against current valids
   logic [`IB_DEPTH-1:1] i1_wen;
   logic [`IB_DEPTH-1:0] val_or;
   logic [`IB_DEPTH-1:0] val_d;

   // move a valid image down by 0, 1 or 2 entries
   function automatic logic [`IB_DEPTH-1:0] shift_image(
      input logic [`IB_DEPTH-1:0] v,
      input logic                 s0,
      input logic                 s1,
      input logic                 s2
   );
      logic [`IB_DEPTH-1:0] r;
      r = ({`IB_DEPTH{s0}} & v) |
          ({`IB_DEPTH{s1}} & {1'b0, v[`IB_DEPTH-1:1]}) |
          ({`IB_DEPTH{s2}} & {2'b0, v[`IB_DEPTH-1:2]});
      return r;
   endfunction

   always_ff @(posedge clk) begin
      if (!rst_n) flush_q <= 1'b0;
      else        flush_q <= flush;
   end

   // room check, slot 1 never alone
   assign i0_acc = i0_valid & ~ib_valid[3] & ~flush_q;
   assign i1_acc = i1_valid & ~ib_valid[2] & i0_acc;

   assign shift0 = ~i0_decode;
   assign shift1 =  i0_decode & ~i1_decode;
   assign shift2 =  i0_decode &  i1_decode;

   assign shift_val = shift_image(ib_valid, shift0, shift1, shift2);

   always_comb begin
      ctl.wr_i0[0] = ~shift_val[0] & (i0_acc | dbg_active);
      ctl.wr_i0[1] =  shift_val[0] & ~shift_val[1] & i0_acc;
      ctl.wr_i0[2] =  shift_val[1] & ~shift_val[2] & i0_acc;
      ctl.wr_i0[3] =  shift_val[2] & ~shift_val[3] & i0_acc;

      // slot 1 lands one entry above slot 0
      ctl.wr_i1[1] = ~shift_val[0] & i1_acc;
      ctl.wr_i1[2] =  shift_val[0] & ~shift_val[1] & i1_acc;
      ctl.wr_i1[3] =  shift_val[1] & ~shift_val[2] & i1_acc;

      // only move entries that hold something
      ctl.sh_1_0 = shift1 & ib_valid[1];
      ctl.sh_2_1 = shift1 & ib_valid[2];
      ctl.sh_3_2 = shift1 & ib_valid[3];
      ctl.sh_2_0 = shift2 & ib_valid[2];
      ctl.sh_3_1 = shift2 & ib_valid[3];
   end

   assign i0_wen[0] = ~ib_valid[0]                & (i0_acc | dbg_active);
   assign i0_wen[1] =  ib_valid[0] & ~ib_valid[1] & i0_acc;
   assign i0_wen[2] =  ib_valid[1] & ~ib_valid[2] & i0_acc;
   assign i0_wen[3] =  ib_valid[2] & ~ib_valid[3] & i0_acc;

   assign i1_wen[1] = ~ib_valid[0]                & i1_acc;
   assign i1_wen[2] =  ib_valid[0] & ~ib_valid[1] & i1_acc;
   assign i1_wen[3] =  ib_valid[1] & ~ib_valid[2] & i1_acc;

   assign val_or = ib_valid | i0_wen | {i1_wen, 1'b0};
   assign val_d  = shift_image(val_or, shift0, shift1, shift2) & ~{`IB_DEPTH{flush_q}};

   always_ff @(posedge clk) begin
      if (!rst_n) ib_valid <= '0;
      else        ib_valid <= val_d;
   end

endmodule

// File: src/ib_entry_array.sv
// instruction buffer payload storage
// four shifting entries of one payload type; entries 0 and 1 feed
// decode, selects come from the valid controller

`timescale 1ns/100ps

`include "ib_params.svh"

module ib_entry_array
   import ib_pkg::*;
#(
   parameter type payload_t = logic [`INSTR_W-1:0]
)(
   input  logic     clk,
   input  payload_t i0_in,    // fetch slot 0
   input  payload_t i1_in,    // fetch slot 1
   input  payload_t head_in,  // slot 0 or debug, entry 0 only
   input  ib_ctl_t  ctl,
   output payload_t i0_out,
   output payload_t i1_out
);

   payload_t ent_q [`IB_DEPTH];
   payload_t ent_d [`IB_DEPTH];

   always_comb begin
      ent_d = ent_q;  // hold by default

      // entry 0
      if (ctl.wr_i0[0])   ent_d[0] = head_in;
      else if (ctl.sh_1_0) ent_d[0] = ent_q[1];
      else if (ctl.sh_2_0) ent_d[0] = ent_q[2];

      // entry 1
      if (ctl.wr_i0[1])   ent_d[1] = i0_in;
      else if (ctl.wr_i1[1]) ent_d[1] = i1_in;
      else if (ctl.sh_2_1) ent_d[1] = ent_q[2];
      else if (ctl.sh_3_1) ent_d[1] = ent_q[3];

      // entry 2
      if (ctl.wr_i0[2])   ent_d[2] = i0_in;
      else if (ctl.wr_i1[2]) ent_d[2] = i1_in;
      else if (ctl.sh_3_2) ent_d[2] = ent_q[3];

      // entry 3, nothing above it
      if (ctl.wr_i0[3])   ent_d[3] = i0_in;
      else if (ctl.wr_i1[3]) ent_d[3] = i1_in;
   end

   always_ff @(posedge clk) begin
      ent_q <= ent_d;
   end

   assign i0_out = ent_q[0];
   assign i1_out = ent_q[1];

endmodule

// File: src/debug_cmd_xlate.sv
// debug command translator
// turns a gpr or csr debug access into an instruction for entry 0
// and flags write data on rs1 and the debug fence for decode

`timescale 1ns/100ps

`include "ib_params.svh"

module debug_cmd_xlate
   import ib_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  dbg_cmd_t            cmd,
   output logic                dbg_active,
   output logic [`INSTR_W-1:0] dbg_instr,
   output logic                dbg_wdata_rs1,
   output logic                dbg_fence
);

   logic        rd_gpr;
   logic        wr_gpr;
   logic        rd_csr;
   logic        wr_csr;
   logic [4:0]  dreg;
   logic [11:0] dcsr;
   logic        fence_d;

   // memory commands are handled elsewhere
   assign dbg_active = cmd.valid & (cmd.cmd_type != `DBG_TYPE_MEM);

   assign rd_gpr = dbg_active & ~cmd.write & (cmd.cmd_type == `DBG_TYPE_GPR);
   assign wr_gpr = dbg_active &  cmd.write & (cmd.cmd_type == `DBG_TYPE_GPR);
   assign rd_csr = dbg_active & ~cmd.write & (cmd.cmd_type == `DBG_TYPE_CSR);
   assign wr_csr = dbg_active &  cmd.write & (cmd.cmd_type == `DBG_TYPE_CSR);

   assign dreg = cmd.addr[4:0];
   assign dcsr = cmd.addr[11:0];

   always_comb begin
      dbg_instr = '0;
      if (rd_gpr) begin
         // or x0, reg, x0 puts the register on the result bus
         dbg_instr = {7'b0, 5'b0, dreg, `F3_OR, 5'b0, `OPC_OP};
      end
      else if (wr_gpr) begin
         dbg_instr = {7'b0, 5'b0, 5'b0, `F3_OR, dreg, `OPC_OP};  // or reg, x0, x0
      end
      else if (rd_csr) begin
         dbg_instr = {dcsr, 5'b0, `F3_CSRRS, 5'b0, `OPC_SYSTEM};  // csrrs x0, csr, x0
      end
      else if (wr_csr) begin
         dbg_instr = {dcsr, 5'b0, `F3_CSRRW, 5'b0, `OPC_SYSTEM};  // csrrw x0, csr, x0
      end
   end

   assign fence_d = wr_csr & (dcsr == `CSR_DFENCE);

   // core is halted and empty, the inst decodes the next cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dbg_wdata_rs1 <= 1'b0;
         dbg_fence     <= 1'b0;
      end
      else begin
         dbg_wdata_rs1 <= wr_gpr | wr_csr;
         dbg_fence     <= fence_d;
      end
   end

endmodule

// File: src/ib_top.sv
// instruction buffer top level
// four-entry dual-issue buffer between the aligner and decode, with
// debug instruction injection at the head

`timescale 1ns/100ps

`include "ib_params.svh"

module ib_top
   import ib_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  fetch_slot_t          i0_slot,
   input  fetch_slot_t          i1_slot,
   input  dbg_cmd_t             dbg_cmd,
   input  logic                 flush,
   input  logic                 i0_decode,
   input  logic                 i1_decode,  // only with i0_decode
   output logic [`IB_DEPTH-1:0] ib_valid,
   output logic [`INSTR_W-1:0]  i0_instr,
   output logic [`INSTR_W-1:0]  i1_instr,
   output ib_pc_pkt_t           i0_pc_pkt,
   output ib_pc_pkt_t           i1_pc_pkt,
   output logic                 dbg_wdata_rs1,
   output logic                 dbg_fence
);

   ib_ctl_t             ctl;
   logic                dbg_active;
   logic [`INSTR_W-1:0] dbg_instr;
   logic [`INSTR_W-1:0] head_instr;

   ib_valid_ctl ib_valid_ctl_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (flush),
      .i0_valid   (i0_slot.valid),
      .i1_valid   (i1_slot.valid),
      .dbg_active (dbg_active),
      .i0_decode  (i0_decode),
      .i1_decode  (i1_decode),
      .ctl        (ctl),
      .ib_valid   (ib_valid)
   );

   debug_cmd_xlate debug_cmd_xlate_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .cmd           (dbg_cmd),
      .dbg_active    (dbg_active),
      .dbg_instr     (dbg_instr),
      .dbg_wdata_rs1 (dbg_wdata_rs1),
      .dbg_fence     (dbg_fence)
   );

   // debug inst takes the slot 0 write into entry 0
   assign head_instr = dbg_active ? dbg_instr : i0_slot.instr;

   ib_entry_array #(
      .payload_t (logic [`INSTR_W-1:0])
   ) instr_array (
      .clk     (clk),
      .i0_in   (i0_slot.instr),
      .i1_in   (i1_slot.instr),
      .head_in (head_instr),
      .ctl     (ctl),
      .i0_out  (i0_instr),
      .i1_out  (i1_instr)
   );

   ib_entry_array #(
      .payload_t (ib_pc_pkt_t)
   ) pc_array (
      .clk     (clk),
      .i0_in   (i0_slot.pc_pkt),
      .i1_in   (i1_slot.pc_pkt),
      .head_in (i0_slot.pc_pkt),
      .ctl     (ctl),
      .i0_out  (i0_pc_pkt),
      .i1_out  (i1_pc_pkt)
   );

endmodule

// File: bench/ib_props.sv
// instruction buffer properties
// valid bits stay packed from entry 0 and a flush empties the buffer
// two edges after it is seen

`timescale 1ns/100ps

`include "ib_params.svh"

module ib_props
   import ib_pkg::*;
(
   input logic                 clk,
   input logic                 rst_n,
   input logic                 flush,
   input logic [`IB_DEPTH-1:0] ib_valid
);

   int fail_count;  // failed assertion count

   initial fail_count = 0;

   a_contig: assert property (@(posedge clk) disable iff (!rst_n)
      ib_valid inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
      else begin
         $error("valid bits are not contiguous from entry 0");
         fail_count++;
      end

   // registered flush clears the valids on the following edge
   a_flush: assert property (@(posedge clk) disable iff (!rst_n)
      flush |-> ##2 (ib_valid == '0))
      else begin
         $error("valids not cleared two cycles after flush");
         fail_count++;
      end

endmodule

bind ib_valid_ctl ib_props ib_props_inst (
   .clk      (clk),
   .rst_n    (rst_n),
   .flush    (flush),
   .ib_valid (ib_valid)
);

// File: bench/ib_checker.sv
// instruction buffer checker
// samples the DUT outputs between edges, compares them with the
// expected values of the pattern line and reports per test

`timescale 1ns/100ps

`include "ib_params.svh"

module ib_checker
   import ib_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 chk_en,
   input  logic [7:0]           test_num,
   input  logic [`IB_DEPTH-1:0] exp_valid,
   input  logic [`INSTR_W-1:0]  exp_i0_instr,
   input  logic [`INSTR_W-1:0]  exp_i1_instr,
   input  ib_pc_pkt_t           exp_i0_pkt,
   input  ib_pc_pkt_t           exp_i1_pkt,
   input  logic                 exp_wdata,
   input  logic                 exp_fence,
   input  logic [`IB_DEPTH-1:0] ib_valid,
   input  logic [`INSTR_W-1:0]  i0_instr,
   input  logic [`INSTR_W-1:0]  i1_instr,
   input  ib_pc_pkt_t           i0_pc_pkt,
   input  ib_pc_pkt_t           i1_pc_pkt,
   input  logic                 dbg_wdata_rs1,
   input  logic                 dbg_fence,
   input  logic                 done,
   output logic                 reported,
   output int                   tests_passed,
   output int                   tests_failed,
   output int                   err_count
);

   logic                 en_q;
   logic [7:0]           t_q;
   logic [`IB_DEPTH-1:0] ev_q;
   logic [`INSTR_W-1:0]  ei0_q;
   logic [`INSTR_W-1:0]  ei1_q;
   ib_pc_pkt_t           ep0_q;
   ib_pc_pkt_t           ep1_q;
   logic                 ewd_q;
   logic                 efc_q;
   logic                 started;
   logic [7:0]           cur_test;
   int                   cur_errs;

   // the line driven at the last edge is due after this edge
   always_ff @(posedge clk) begin
      en_q  <= chk_en;
      t_q   <= test_num;
      ev_q  <= exp_valid;
      ei0_q <= exp_i0_instr;
      ei1_q <= exp_i1_instr;
      ep0_q <= exp_i0_pkt;
      ep1_q <= exp_i1_pkt;
      ewd_q <= exp_wdata;
      efc_q <= exp_fence;
   end

   task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         $display("[ERROR] time %0t: %s expected %h actual %h", $time, name, exp, act);
         cur_errs++;
         err_count++;
      end
   endtask

   task automatic close_test();
      if (cur_errs == 0) begin
         $display("test %0d passed", cur_test);
         tests_passed++;
      end
      else begin
         $display("test %0d failed with %0d errors", cur_test, cur_errs);
         tests_failed++;
      end
      cur_errs = 0;
   endtask

   always @(negedge clk) begin
      if (!rst_n) begin
         started      = 1'b0;
         reported     = 1'b0;
         cur_test     = '0;
         cur_errs     = 0;
         tests_passed = 0;
         tests_failed = 0;
         err_count    = 0;
      end
      else begin
         if (en_q) begin
            if (!started) begin
               started  = 1'b1;
               cur_test = t_q;
            end
            else if (t_q != cur_test) begin
               close_test();
               cur_test = t_q;
            end
            check_val("ib_valid", {60'b0, ev_q}, {60'b0, ib_valid});
            if (ev_q[0]) begin  // entry 0 payload is unknown until written
               check_val("i0_instr", {32'b0, ei0_q}, {32'b0, i0_instr});
               check_val("i0_pc_pkt", {27'b0, ep0_q}, {27'b0, i0_pc_pkt});
            end
            if (ev_q[1]) begin
               check_val("i1_instr", {32'b0, ei1_q}, {32'b0, i1_instr});
               check_val("i1_pc_pkt", {27'b0, ep1_q}, {27'b0, i1_pc_pkt});
            end
            check_val("dbg_wdata_rs1", {63'b0, ewd_q}, {63'b0, dbg_wdata_rs1});
            check_val("dbg_fence", {63'b0, efc_q}, {63'b0, dbg_fence});
         end
         if (done && !reported) begin
            if (started) close_test();
            reported = 1'b1;
         end
      end
   end

endmodule

// File: bench/tb_ib.sv
// instruction buffer testbench
// reads per-cycle stimulus and expected values from the pattern file,
// drives the DUT and hands the expected values to the checker

`timescale 1ns/100ps

`include "ib_params.svh"

module tb_ib
   import ib_pkg::*;
();

   localparam int MAX_LINES = 500;   // bound on the pattern read loop
   localparam int DONE_WAIT = 20;    // cycles allowed for the final report

   logic                 clk;
   logic                 rst_n;
   fetch_slot_t          i0_slot;
   fetch_slot_t          i1_slot;
   dbg_cmd_t             dbg_cmd;
   logic                 flush;
   logic                 i0_decode;
   logic                 i1_decode;
   logic [`IB_DEPTH-1:0] ib_valid;
   logic [`INSTR_W-1:0]  i0_instr;
   logic [`INSTR_W-1:0]  i1_instr;
   ib_pc_pkt_t           i0_pc_pkt;
   ib_pc_pkt_t           i1_pc_pkt;
   logic                 dbg_wdata_rs1;
   logic                 dbg_fence;

   // expected values for the checker
   logic                 chk_en;
   logic [7:0]           test_num;
   logic [`IB_DEPTH-1:0] exp_valid;
   logic [`INSTR_W-1:0]  exp_i0_instr;
   logic [`INSTR_W-1:0]  exp_i1_instr;
   ib_pc_pkt_t           exp_i0_pkt;
   ib_pc_pkt_t           exp_i1_pkt;
   logic                 exp_wdata;
   logic                 exp_fence;
   logic                 done;
   logic                 reported;
   int                   tests_passed;
   int                   tests_failed;
   int                   err_count;
   int                   prop_fails;

   // one parsed pattern line
   int                   fd;
   int                   r;
   int                   nlines;
   int                   wait_cycles;
   string                line;
   int                   p_t;
   logic                 p_i0v;
   logic                 p_i1v;
   logic [31:0]          p_i0i;
   logic [31:0]          p_i1i;
   logic [36:0]          p_i0p;
   logic [36:0]          p_i1p;
   logic                 p_d0;
   logic                 p_d1;
   logic                 p_fl;
   logic                 p_dv;
   logic                 p_dw;
   logic [1:0]           p_dt;
   logic [31:0]          p_da;
   logic [3:0]           p_ev;
   logic [31:0]          p_ei0;
   logic [31:0]          p_ei1;
   logic [36:0]          p_ep0;
   logic [36:0]          p_ep1;
   logic                 p_wd;
   logic                 p_fc;
   logic                 file_ok;
   logic                 timed_out;

   initial clk = 1'b0;
   always #20 clk = ~clk;

   ib_top ib_top_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .i0_slot       (i0_slot),
      .i1_slot       (i1_slot),
      .dbg_cmd       (dbg_cmd),
      .flush         (flush),
      .i0_decode     (i0_decode),
      .i1_decode     (i1_decode),
      .ib_valid      (ib_valid),
      .i0_instr      (i0_instr),
      .i1_instr      (i1_instr),
      .i0_pc_pkt     (i0_pc_pkt),
      .i1_pc_pkt     (i1_pc_pkt),
      .dbg_wdata_rs1 (dbg_wdata_rs1),
      .dbg_fence     (dbg_fence)
   );

   ib_checker checker_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .chk_en        (chk_en),
      .test_num      (test_num),
      .exp_valid     (exp_valid),
      .exp_i0_instr  (exp_i0_instr),
      .exp_i1_instr  (exp_i1_instr),
      .exp_i0_pkt    (exp_i0_pkt),
      .exp_i1_pkt    (exp_i1_pkt),
      .exp_wdata     (exp_wdata),
      .exp_fence     (exp_fence),
      .ib_valid      (ib_valid),
      .i0_instr      (i0_instr),
      .i1_instr      (i1_instr),
      .i0_pc_pkt     (i0_pc_pkt),
      .i1_pc_pkt     (i1_pc_pkt),
      .dbg_wdata_rs1 (dbg_wdata_rs1),
      .dbg_fence     (dbg_fence),
      .done          (done),
      .reported      (reported),
      .tests_passed  (tests_passed),
      .tests_failed  (tests_failed),
      .err_count     (err_count)
   );

   // drive one parsed line at the next rising edge
   task automatic apply_line();
      @(posedge clk);
      i0_slot      <= {p_i0v, p_i0i, p_i0p};
      i1_slot      <= {p_i1v, p_i1i, p_i1p};
      i0_decode    <= p_d0;
      i1_decode    <= p_d1;
      flush        <= p_fl;
      dbg_cmd      <= {p_dv, p_dw, p_dt, 2'b10, p_da};
      chk_en       <= 1'b1;
      test_num     <= p_t[7:0];
      exp_valid    <= p_ev;
      exp_i0_instr <= p_ei0;
      exp_i1_instr <= p_ei1;
      exp_i0_pkt   <= p_ep0;
      exp_i1_pkt   <= p_ep1;
      exp_wdata    <= p_wd;
      exp_fence    <= p_fc;
   endtask

   task automatic drive_idle();
      @(posedge clk);
      i0_slot   <= '0;
      i1_slot   <= '0;
      dbg_cmd   <= '0;
      flush     <= 1'b0;
      i0_decode <= 1'b0;
      i1_decode <= 1'b0;
      chk_en    <= 1'b0;
   endtask

   initial begin
      rst_n        = 1'b0;
      i0_slot      = '0;
      i1_slot      = '0;
      dbg_cmd      = '0;
      flush        = 1'b0;
      i0_decode    = 1'b0;
      i1_decode    = 1'b0;
      chk_en       = 1'b0;
      test_num     = '0;
      exp_valid    = '0;
      exp_i0_instr = '0;
      exp_i1_instr = '0;
      exp_i0_pkt   = '0;
      exp_i1_pkt   = '0;
      exp_wdata    = 1'b0;
      exp_fence    = 1'b0;
      done         = 1'b0;
      file_ok      = 1'b1;
      timed_out    = 1'b0;
      nlines       = 0;
      prop_fails   = 0;

      fd = $fopen("bench/ib_patterns.txt", "r");
      if (fd == 0) begin
         $display("cannot open the pattern file bench/ib_patterns.txt");
         file_ok = 1'b0;
      end

      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      while (file_ok && !$feof(fd) && nlines < MAX_LINES) begin
         nlines++;
         r = $fgets(line, fd);
         if (r > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
            r = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        p_t, p_i0v, p_i0i, p_i0p, p_i1v, p_i1i, p_i1p, p_d0, p_d1, p_fl,
                        p_dv, p_dw, p_dt, p_da, p_ev, p_ei0, p_ei1, p_ep0, p_ep1, p_wd, p_fc);
            if (r != 21) begin
               $display("malformed pattern line %0d: %s", nlines, line);
               file_ok = 1'b0;
            end
            else begin
               apply_line();
            end
         end
      end
      if (nlines >= MAX_LINES) begin
         $display("pattern file did not end within %0d lines", MAX_LINES);
         timed_out = 1'b1;
      end

      drive_idle();
      @(posedge clk);
      done <= 1'b1;

      wait_cycles = 0;
      while (!reported && wait_cycles < DONE_WAIT) begin
         @(posedge clk);
         wait_cycles++;
      end
      if (!reported) begin
         $display("checker did not report its results within %0d cycles", DONE_WAIT);
         timed_out = 1'b1;
      end

      prop_fails = ib_top_inst.ib_valid_ctl_inst.ib_props_inst.fail_count;
      $display("tests passed %0d, tests failed %0d, value errors %0d, assertion failures %0d",
               tests_passed, tests_failed, err_count, prop_fails);
      if (file_ok && !timed_out && err_count == 0 && tests_failed == 0 && tests_passed > 0 &&
          prop_fails == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: bench/ib_patterns.txt
// test i0v i0_instr i0_pkt i1v i1_instr i1_pkt dec0 dec1 flush dbg_v dbg_w dbg_type dbg_addr
//   then expected: valid i0_instr i1_instr i0_pkt i1_pkt wdata_rs1 fence
1 1 aa000001 0000001001 1 aa000002 0100001005 0 0 0 0 0 0 000 3 aa000001 aa000002 0000001001 0100001005 0 0
1 1 aa000003 0200001009 1 aa000004 040000100d 0 0 0 0 0 0 000 f aa000001 aa000002 0000001001 0100001005 0 0
2 0 00000000 0000000000 0 00000000 0000000000 1 1 0 0 0 0 000 3 aa000003 aa000004 0200001009 040000100d 0 0
2 1 aa000005 0800001011 1 aa000006 1000001015 1 0 0 0 0 0 000 7 aa000004 aa000005 040000100d 0800001011 0 0
2 1 aa000007 0000001019 1 aa000008 000000101d 1 1 0 0 0 0 000 3 aa000006 aa000007 1000001015 0000001019 0 0
2 0 00000000 0000000000 0 00000000 0000000000 1 1 0 0 0 0 000 0 00000000 00000000 0000000000 0000000000 0 0
3 1 aa000009 0000001021 1 aa00000a 0000001025 0 0 0 0 0 0 000 3 aa000009 aa00000a 0000001021 0000001025 0 0
3 1 aa00000b 0000001029 1 aa00000c 000000102d 0 0 0 0 0 0 000 f aa000009 aa00000a 0000001021 0000001025 0 0
3 1 aa00000d 0000001031 1 aa00000e 0000001035 0 0 0 0 0 0 000 f aa000009 aa00000a 0000001021 0000001025 0 0
3 1 aa00000d 0000001031 1 aa00000e 0000001035 1 0 0 0 0 0 000 7 aa00000a aa00000b 0000001025 0000001029 0 0
3 1 aa00000d 0000001031 1 aa00000e 0000001035 0 0 0 0 0 0 000 f aa00000a aa00000b 0000001025 0000001029 0 0
3 0 00000000 0000000000 0 00000000 0000000000 1 1 0 0 0 0 000 3 aa00000c aa00000d 000000102d 0000001031 0 0
3 0 00000000 0000000000 0 00000000 0000000000 1 1 0 0 0 0 000 0 00000000 00000000 0000000000 0000000000 0 0
4 1 aa00000f 0000001039 1 aa000010 000000103d 0 0 0 0 0 0 000 3 aa00000f aa000010 0000001039 000000103d 0 0
4 1 aa000011 0000001041 1 aa000012 0000001045 0 0 1 0 0 0 000 f aa00000f aa000010 0000001039 000000103d 0 0
4 1 aa000013 0000001049 1 aa000014 000000104d 0 0 0 0 0 0 000 0 00000000 00000000 0000000000 0000000000 0 0
4 1 aa000013 0000001049 1 aa000014 000000104d 0 0 0 0 0 0 000 3 aa000013 aa000014 0000001049 000000104d 0 0
4 0 00000000 0000000000 0 00000000 0000000000 1 1 0 0 0 0 000 0 00000000 00000000 0000000000 0000000000 0 0
5 0 00000000 0000000000 0 00000000 0000000000 0 0 0 1 0 0 005 1 0002e033 00000000 0000000000 0000000000 0 0
5 0 00000000 0000000000 0 00000000 0000000000 1 0 0 0 0 0 000 0 00000000 00000000 0000000000 0000000000 0 0
5 0 00000000 0000000000 0 00000000 0000000000 0 0 0 1 1 0 00a 1 00006533 00000000 0000000000 0000000000 1 0
5 0 00000000 0000000000 0 00000000 0000000000 1 0 0 0 0 0 000 0 00000000 00000000 0000000000 0000000000 0 0
5 0 00000000 0000000000 0 00000000 0000000000 0 0 0 1 0 1 300 1 30002073 00000000 0000000000 0000000000 0 0
5 0 00000000 0000000000 0 00000000 0000000000 1 0 0 0 0 0 000 0 00000000 00000000 0000000000 0000000000 0 0
5 0 00000000 0000000000 0 00000000 0000000000 0 0 0 1 1 1 7c4 1 7c401073 00000000 0000000000 0000000000 1 1
5 0 00000000 0000000000 0 00000000 0000000000 1 0 0 0 0 0 000 0 00000000 00000000 0000000000 0000000000 0 0
5 0 00000000 0000000000 0 00000000 0000000000 0 0 0 1 1 1 305 1 30501073 00000000 0000000000 0000000000 1 0
5 0 00000000 0000000000 0 00000000 0000000000 1 0 0 0 0 0 000 0 00000000 00000000 0000000000 0000000000 0 0
5 0 00000000 0000000000 0 00000000 0000000000 0 0 0 1 1 2 100 0 00000000 00000000 0000000000 0000000000 0 0
5 0 00000000 0000000000 0 00000000 0000000000 0 0 0 0 0 0 000 0 00000000 00000000 0000000000 0000000000 0 0

// File: project.f
+incdir+src
src/ib_pkg.sv
src/ib_valid_ctl.sv
src/ib_entry_array.sv
src/debug_cmd_xlate.sv
src/ib_top.sv
bench/ib_props.sv
bench/ib_checker.sv
bench/tb_ib.sv

// File: Makefile
# Verilator build and run for the instruction buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_ib
LOG       ?= sim.log
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard src/*.sv src/*.svh bench/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
